//--- Bender.yml
package:
  name: rtg_display

sources:
  - rtg_pkg.sv
  - rtg_if.sv
  - rtg_regs.sv
  - rtg_palette.sv
  - rtg_timing.sv
  - rtg_fetch.sv
  - rtg_pixel_out.sv
  - rtg_display_top.sv
  - target: test
    files:
      - tb_rtg_mem_model.sv
      - tb_rtg_display.sv

//--- rtg_display_top.sv
/* RTG display path top level
   Register block, palette, timing, fetcher and output stage */
`default_nettype none

module rtg_display_top #(
	parameter int BURST_LEN  = rtg_pkg::BURST_LEN,
	parameter int FIFO_DEPTH = rtg_pkg::FIFO_DEPTH
) (
	input  wire                 CLK_114,
	input  wire                 rst_n,
	// Wishbone
	input  wire                 wb_cyc,
	input  wire                 wb_stb,
	input  wire                 wb_we,
	input  wire  [8:0]          wb_adr,
	input  wire  [31:0]         wb_dat_w,
	output logic [31:0]         wb_dat_r,
	output logic                wb_ack,
	// Memory read port
	output logic                mem_req,
	output rtg_pkg::addr_t      mem_addr,
	input  wire                 mem_fill,
	input  wire rtg_pkg::word_t mem_data,
	// Native video
	input  wire rtg_pkg::chan_t in_r,
	input  wire rtg_pkg::chan_t in_g,
	input  wire rtg_pkg::chan_t in_b,
	input  wire                 in_hs,
	input  wire                 in_vs,
	input  wire                 in_cs,
	input  wire                 hblank,
	input  wire                 vblank,
	input  wire                 osd_window,
	input  wire                 osd_pixel,
	// VGA
	output rtg_pkg::chan_t      vga_r,
	output rtg_pkg::chan_t      vga_g,
	output rtg_pkg::chan_t      vga_b,
	output logic                vga_hs,
	output logic                vga_vs,
	output logic                vga_cs,
	output logic                pixel_strobe
);
	import rtg_pkg::*;

	logic      pal_we;
	clut_idx_t pal_idx;
	rgb_t      pal_rgb;
	clut_idx_t rd_idx;
	rgb_t      rd_rgb;
	word_t     q;        // Current FIFO word

	rtg_cfg_if  cfg_if ();
	rtg_beat_if beat_if ();

	rtg_regs u_regs (
		.CLK_114  (CLK_114),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.cfg      (cfg_if.source),
		.pal_we   (pal_we),
		.pal_idx  (pal_idx),
		.pal_rgb  (pal_rgb)
	);

	rtg_palette u_palette (
		.CLK_114 (CLK_114),
		.pal_we  (pal_we),
		.pal_idx (pal_idx),
		.pal_rgb (pal_rgb),
		.rd_idx  (rd_idx),
		.rd_rgb  (rd_rgb)
	);

	rtg_timing u_timing (
		.CLK_114      (CLK_114),
		.rst_n        (rst_n),
		.cfg          (cfg_if.sink),
		.hblank       (hblank),
		.vblank       (vblank),
		.hs           (in_hs),    // Blank counts native hsync edges
		.beat         (beat_if.source),
		.pixel_strobe (pixel_strobe)
	);

	rtg_fetch #(
		.BURST_LEN  (BURST_LEN),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fetch (
		.CLK_114  (CLK_114),
		.rst_n    (rst_n),
		.cfg      (cfg_if.sink),
		.beat     (beat_if.sink),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_fill (mem_fill),
		.mem_data (mem_data),
		.q        (q)
	);

	rtg_pixel_out u_pixel_out (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.cfg        (cfg_if.sink),
		.beat       (beat_if.sink),
		.q          (q),
		.pal_rgb    (rd_rgb),
		.rd_idx     (rd_idx),
		.in_r       (in_r),
		.in_g       (in_g),
		.in_b       (in_b),
		.in_hs      (in_hs),
		.in_vs      (in_vs),
		.in_cs      (in_cs),
		.osd_window (osd_window),
		.osd_pixel  (osd_pixel),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.vga_cs     (vga_cs)
	);

endmodule

`default_nettype wire

//--- rtg_fetch.sv
/* Burst fetcher from external memory into a word FIFO
   Each fetch strobe pops one word to the display */
`default_nettype none

module rtg_fetch #(
	parameter int BURST_LEN  = rtg_pkg::BURST_LEN,
	parameter int FIFO_DEPTH = rtg_pkg::FIFO_DEPTH
) (
	input  wire                 CLK_114,
	input  wire                 rst_n,
	rtg_cfg_if.sink             cfg,
	rtg_beat_if.sink            beat,
	output logic                mem_req,
	output rtg_pkg::addr_t      mem_addr,
	input  wire                 mem_fill,
	input  wire rtg_pkg::word_t mem_data,
	output rtg_pkg::word_t      q
);
	import rtg_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int LVL_W = $clog2(FIFO_DEPTH + 1);
	localparam int CNT_W = $clog2(BURST_LEN + 1);

	fetch_state_t     state;
	addr_t            addr;
	logic [CNT_W-1:0] fill_cnt;
	logic             drop;       // Burst abandoned by a restart
	word_t            fifo [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LVL_W-1:0] level;
	logic             flush;
	logic             push;
	logic             pop;
	logic             last_fill;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign flush     = beat.restart | ~cfg.enable;
	assign push      = mem_fill && (state != IDLE) && !drop && !flush;
	assign pop       = beat.fetch && (level != '0) && !flush;  // Empty repeats q
	assign last_fill = mem_fill && (state != IDLE) && (fill_cnt == CNT_W'(BURST_LEN - 1));
	assign mem_req   = (state != IDLE);  // Held up to the last fill
	assign mem_addr  = addr;

	//////////////////////////////////////////////////////////////////////
	// Burst FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			addr     <= '0;
			fill_cnt <= '0;
			drop     <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					fill_cnt <= '0;
					drop     <= 1'b0;
					if (flush)
						addr <= cfg.base_addr;  // Frame restarts at the base
					else if (int'(level) <= FIFO_DEPTH - BURST_LEN)
						state <= REQ;           // Room for a whole burst
				end
				REQ, FILL: begin
					if (flush)
						drop <= 1'b1;
					if (mem_fill) begin
						fill_cnt <= fill_cnt + 1'b1;
						state    <= FILL;
					end
					if (last_fill) begin
						state <= IDLE;
						addr  <= (drop || flush) ? cfg.base_addr : addr + addr_t'(BURST_LEN);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// FIFO
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			level <= level + LVL_W'(push) - LVL_W'(pop);
		end
	end

	always_ff @(posedge CLK_114) begin
		if (push)
			fifo[wr_ptr] <= mem_data;
		if (pop)
			q <= fifo[rd_ptr];
	end

	a_no_overflow: assert property (@(posedge CLK_114) disable iff (!rst_n)
		push |-> int'(level) < FIFO_DEPTH)
		else $error("Push into full FIFO");

endmodule

`default_nettype wire

//--- rtg_if.sv
/* Configuration and pixel beat bundles for the RTG display path */
`default_nettype none

interface rtg_cfg_if;
	import rtg_pkg::*;

	logic       enable;
	logic       clut;
	logic       ext;
	logic       hpol;
	logic       vpol;
	logic       lowres;
	pix_width_t pix_width;
	vbend_t     vbend;
	addr_t      base_addr;

	modport source (output enable, clut, ext, hpol, vpol, lowres, pix_width, vbend, base_addr);
	modport sink   (input  enable, clut, ext, hpol, vpol, lowres, pix_width, vbend, base_addr);
endinterface

interface rtg_beat_if;
	logic fetch;      // FIFO pop
	logic blank_dly;  // Blank aligned to pixel data
	logic byte_sel;   // Low byte as palette index
	logic restart;    // Native vblank, flushes the fetcher

	modport source (output fetch, blank_dly, byte_sel, restart);
	modport sink   (input  fetch, blank_dly, byte_sel, restart);
endinterface

`default_nettype wire

//--- rtg_palette.sv
/* 256-entry colour lookup RAM, one write port and a registered read */
`default_nettype none

module rtg_palette (
	input  wire                     CLK_114,
	input  wire                     pal_we,
	input  wire rtg_pkg::clut_idx_t pal_idx,
	input  wire rtg_pkg::rgb_t      pal_rgb,
	input  wire rtg_pkg::clut_idx_t rd_idx,
	output rtg_pkg::rgb_t           rd_rgb
);
	import rtg_pkg::*;

	rgb_t clut [256];  // Maps to one block RAM

	always_ff @(posedge CLK_114) begin
		if (pal_we)
			clut[pal_idx] <= pal_rgb;
		rd_rgb <= clut[rd_idx];  // One cycle behind the index
	end

endmodule

`default_nettype wire

//--- rtg_pixel_out.sv
/* Colour expansion, RTG or native source select, OSD overlay
   and sync polarity for the VGA outputs */
`default_nettype none

module rtg_pixel_out (
	input  wire                 CLK_114,
	input  wire                 rst_n,
	rtg_cfg_if.sink             cfg,
	rtg_beat_if.sink            beat,
	input  wire rtg_pkg::word_t q,
	input  wire rtg_pkg::rgb_t  pal_rgb,
	output rtg_pkg::clut_idx_t  rd_idx,
	input  wire rtg_pkg::chan_t in_r,
	input  wire rtg_pkg::chan_t in_g,
	input  wire rtg_pkg::chan_t in_b,
	input  wire                 in_hs,
	input  wire                 in_vs,
	input  wire                 in_cs,
	input  wire                 osd_window,
	input  wire                 osd_pixel,
	output rtg_pkg::chan_t      vga_r,
	output rtg_pkg::chan_t      vga_g,
	output rtg_pkg::chan_t      vga_b,
	output logic                vga_hs,
	output logic                vga_vs,
	output logic                vga_cs
);
	import rtg_pkg::*;

	chan_t hc_r;  // 5-5-5 expanded
	chan_t hc_g;
	chan_t hc_b;
	chan_t r_reg;
	chan_t g_reg;
	chan_t b_reg;
	logic  hs_reg;
	logic  vs_reg;
	logic  cs_reg;
	logic  rtg_sel;

	// OSD forces the top two bits, picture shows dimmed below
	function automatic chan_t osd_mix(input chan_t c, input logic [1:0] top);
		return osd_window ? {top, c[7:2]} : c;
	endfunction

	assign rd_idx = beat.byte_sel ? q[7:0] : q[15:8];  // High byte first

	assign hc_r = {q[14:10], q[14:12]};
	assign hc_g = {q[9:5], q[9:7]};
	assign hc_b = {q[4:0], q[4:2]};

	assign rtg_sel = cfg.enable & ~beat.blank_dly;

	always_ff @(posedge CLK_114) begin
		r_reg <= rtg_sel ? (cfg.clut ? pal_rgb[23:16] : hc_r) : in_r;
		g_reg <= rtg_sel ? (cfg.clut ? pal_rgb[15:8] : hc_g) : in_g;
		b_reg <= rtg_sel ? (cfg.clut ? pal_rgb[7:0] : hc_b) : in_b;
	end

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			hs_reg <= 1'b0;
			vs_reg <= 1'b0;
			cs_reg <= 1'b0;
		end else begin
			hs_reg <= in_hs;
			vs_reg <= in_vs;
			cs_reg <= in_cs;
		end
	end

	assign vga_r  = osd_mix(r_reg, {osd_pixel, osd_pixel});
	assign vga_g  = osd_mix(g_reg, {osd_pixel, osd_pixel});
	assign vga_b  = osd_mix(b_reg, {1'b1, osd_pixel});  // OSD background is blue
	assign vga_hs = hs_reg ^ cfg.hpol;
	assign vga_vs = vs_reg ^ cfg.vpol;
	assign vga_cs = cs_reg;

endmodule

`default_nettype wire

//--- rtg_pkg.sv
/* RTG display path shared definitions
   Widths, register map and fetch FSM states */
`default_nettype none

package rtg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data widths
	//////////////////////////////////////////////////////////////////////
	typedef logic [15:0] word_t;       // External memory word
	typedef logic [23:0] addr_t;       // Word address
	typedef logic [23:0] rgb_t;        // 8-8-8 colour
	typedef logic [7:0]  chan_t;       // One colour channel
	typedef logic [7:0]  clut_idx_t;   // Palette index
	typedef logic [3:0]  pix_width_t;  // Clocks per fetch minus one
	typedef logic [6:0]  vbend_t;      // Lines of blank after native vblank

	//////////////////////////////////////////////////////////////////////
	// Register map, 9-bit word address
	//////////////////////////////////////////////////////////////////////
	localparam logic [8:0] REG_CTRL   = 9'd0;
	localparam logic [8:0] REG_TIMING = 9'd1;
	localparam logic [8:0] REG_BASE   = 9'd2;
	localparam logic [8:0] PAL_BASE   = 9'd256;  // Palette occupies 256..511

	localparam int CTRL_ENABLE = 0;  // RTG on
	localparam int CTRL_CLUT   = 1;  // 8-bit indexed mode
	localparam int CTRL_EXT    = 2;  // Extra fetch at blank start
	localparam int CTRL_HPOL   = 3;
	localparam int CTRL_VPOL   = 4;
	localparam int CTRL_LOWRES = 5;  // Native strobe every 4 clocks

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		FILL
	} fetch_state_t;

	localparam int BURST_LEN  = 4;   // Words per memory burst
	localparam int FIFO_DEPTH = 16;

endpackage

`default_nettype wire

//--- rtg_regs.sv
/* RTG configuration registers on a Wishbone classic slave
   Palette range writes go straight to the colour lookup RAM */
`default_nettype none

module rtg_regs (
	input  wire                CLK_114,
	input  wire                rst_n,
	input  wire                wb_cyc,
	input  wire                wb_stb,
	input  wire                wb_we,
	input  wire  [8:0]         wb_adr,
	input  wire  [31:0]        wb_dat_w,
	output logic [31:0]        wb_dat_r,
	output logic               wb_ack,
	rtg_cfg_if.source          cfg,
	output logic               pal_we,
	output rtg_pkg::clut_idx_t pal_idx,
	output rtg_pkg::rgb_t      pal_rgb
);
	import rtg_pkg::*;

	logic wr_stb;  // Write commits during the ack cycle
	logic pal_sel;

	assign wr_stb  = wb_cyc & wb_stb & wb_we & wb_ack;
	assign pal_sel = (wb_adr >= PAL_BASE);

	assign pal_we  = wr_stb & pal_sel;  // Single cycle, ack is one cycle
	assign pal_idx = wb_adr[7:0];
	assign pal_rgb = wb_dat_w[23:0];

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack        <= 1'b0;
			cfg.enable    <= 1'b0;
			cfg.clut      <= 1'b0;
			cfg.ext       <= 1'b0;
			cfg.hpol      <= 1'b0;
			cfg.vpol      <= 1'b0;
			cfg.lowres    <= 1'b0;
			cfg.pix_width <= '0;
			cfg.vbend     <= '0;
			cfg.base_addr <= '0;
		end else begin
			wb_ack <= wb_cyc & wb_stb & ~wb_ack;  // One-cycle answer
			if (wr_stb && !pal_sel) begin
				case (wb_adr)
					REG_CTRL: begin
						cfg.enable <= wb_dat_w[CTRL_ENABLE];
						cfg.clut   <= wb_dat_w[CTRL_CLUT];
						cfg.ext    <= wb_dat_w[CTRL_EXT];
						cfg.hpol   <= wb_dat_w[CTRL_HPOL];
						cfg.vpol   <= wb_dat_w[CTRL_VPOL];
						cfg.lowres <= wb_dat_w[CTRL_LOWRES];
					end
					REG_TIMING: begin
						cfg.pix_width <= wb_dat_w[3:0];
						cfg.vbend     <= wb_dat_w[14:8];  // Line count in upper byte
					end
					REG_BASE: cfg.base_addr <= wb_dat_w[23:0];
					default: ;
				endcase
			end
		end
	end

	// Readback, palette and holes read zero
	always_comb begin
		wb_dat_r = '0;
		case (wb_adr)
			REG_CTRL: begin
				wb_dat_r[CTRL_ENABLE] = cfg.enable;
				wb_dat_r[CTRL_CLUT]   = cfg.clut;
				wb_dat_r[CTRL_EXT]    = cfg.ext;
				wb_dat_r[CTRL_HPOL]   = cfg.hpol;
				wb_dat_r[CTRL_VPOL]   = cfg.vpol;
				wb_dat_r[CTRL_LOWRES] = cfg.lowres;
			end
			REG_TIMING: begin
				wb_dat_r[3:0]  = cfg.pix_width;
				wb_dat_r[14:8] = cfg.vbend;
			end
			REG_BASE: wb_dat_r[23:0] = cfg.base_addr;
			default: ;
		endcase
	end

	a_ack_single: assert property (@(posedge CLK_114) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held for two cycles");

endmodule

`default_nettype wire

//--- rtg_timing.sv
/* RTG pixel pacing and blank generation
   Drives FIFO pops, palette byte select and the outgoing pixel strobe */
`default_nettype none

module rtg_timing (
	input  wire         CLK_114,
	input  wire         rst_n,
	rtg_cfg_if.sink     cfg,
	input  wire         hblank,
	input  wire         vblank,
	input  wire         hs,
	rtg_beat_if.source  beat,
	output logic        pixel_strobe
);
	import rtg_pkg::*;

	logic       hs_d;
	logic       rtg_vblank;   // Stretched vertical blank
	vbend_t     vb_cnt;       // hsync edges since native vblank
	logic       blank;
	logic       blank_d;
	logic       blank_d2;
	pix_width_t pix_ctr;
	logic       sel;          // Second half of the pixel
	logic       sel_d;
	logic       fetch;
	logic       fetch_d;
	logic [2:0] div_ctr;      // Native pixel divider
	logic       native_strobe;

	assign blank = rtg_vblank | hblank;

	// Extended mode also fetches in the first blank clock
	assign fetch = cfg.enable && (!blank || (!blank_d && cfg.ext))
		&& (pix_ctr == cfg.pix_width);

	assign native_strobe = (div_ctr == 3'd0);

	assign beat.fetch     = fetch;
	assign beat.blank_dly = blank_d2;
	assign beat.byte_sel  = sel;
	assign beat.restart   = vblank;

	assign pixel_strobe = cfg.enable ? (fetch_d | (sel & ~sel_d & cfg.clut)) : native_strobe;

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			hs_d       <= 1'b0;
			rtg_vblank <= 1'b0;
			vb_cnt     <= '0;
			blank_d    <= 1'b0;
			blank_d2   <= 1'b0;
			pix_ctr    <= '0;
			sel        <= 1'b0;
			sel_d      <= 1'b0;
			fetch_d    <= 1'b0;
			div_ctr    <= 3'd1;  // Keeps the strobe low out of reset
		end else begin
			hs_d     <= hs;
			blank_d  <= blank;
			blank_d2 <= blank_d;
			sel_d    <= sel;
			fetch_d  <= fetch;
			div_ctr  <= cfg.lowres ? {div_ctr[2:1], 1'b0} + 3'd2 : div_ctr + 3'd1;

			if (vblank) begin  // Blank starts with the native one
				rtg_vblank <= 1'b1;
				vb_cnt     <= '0;
			end else if (vb_cnt == cfg.vbend) begin
				rtg_vblank <= 1'b0;
			end else if (hs && !hs_d) begin
				vb_cnt <= vb_cnt + 1'b1;
			end

			if (blank || fetch) begin
				pix_ctr <= '0;
				sel     <= 1'b0;
			end else begin
				pix_ctr <= pix_ctr + 1'b1;
				if (pix_ctr == {1'b0, cfg.pix_width[3:1]})  // Half width
					sel <= 1'b1;
			end
		end
	end

	// A blanked fetch only comes from the ext rule at the blank edge
	a_no_blank_fetch: assert property (@(posedge CLK_114) disable iff (!rst_n)
		fetch && blank |-> cfg.ext && !$past(blank))
		else $error("Fetch during blank");

endmodule

`default_nettype wire

//--- sources.f
rtg_pkg.sv
rtg_if.sv
rtg_regs.sv
rtg_palette.sv
rtg_timing.sv
rtg_fetch.sv
rtg_pixel_out.sv
rtg_display_top.sv
tb_rtg_mem_model.sv
tb_rtg_display.sv

//--- tb_rtg_display.sv
/* Directed testbench for the RTG display path
   Wishbone setup, native passthrough, fetch order, high-colour and CLUT output */
`default_nettype none

module tb_rtg_display;
	timeunit 1ns;
	timeprecision 1ps;
	import rtg_pkg::*;

	localparam int    TIMEOUT   = 2000;          // Clocks per wait loop
	localparam int    N_WORDS   = 24;            // Words checked per picture test
	localparam addr_t BASE      = 24'h12_0100;   // Frame start in memory
	localparam addr_t CLUT_BASE = 24'h12_d100;   // Words from 16'he334, high byte unlike frame one

	logic        CLK_114;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [8:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic        mem_req;
	addr_t       mem_addr;
	logic        mem_fill;
	word_t       mem_data;
	chan_t       in_r;
	chan_t       in_g;
	chan_t       in_b;
	logic        in_hs;
	logic        in_vs;
	logic        in_cs;
	logic        hblank;
	logic        vblank;
	logic        osd_window;
	logic        osd_pixel;
	chan_t       vga_r;
	chan_t       vga_g;
	chan_t       vga_b;
	logic        vga_hs;
	logic        vga_vs;
	logic        vga_cs;
	logic        pixel_strobe;

	integer seed;
	rgb_t   exp_seq [$];  // Expected colours in display order

	rtg_display_top #(
		.BURST_LEN  (BURST_LEN),
		.FIFO_DEPTH (FIFO_DEPTH)
	) uut (.*);

	tb_rtg_mem_model #(
		.BURST_LEN (BURST_LEN)
	) u_mem (
		.CLK_114  (CLK_114),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_fill (mem_fill),
		.mem_data (mem_data)
	);

	initial CLK_114 = 1'b0;
	always #4 CLK_114 = ~CLK_114;  // 8 ns period

	//////////////////////////////////////////////////////////////////////
	// Reference rules
	//////////////////////////////////////////////////////////////////////
	function automatic word_t mem_word(input addr_t a);
		return word_t'(a) + 16'h1234;
	endfunction

	function automatic rgb_t expand_555(input word_t w);
		return {w[14:10], w[14:12], w[9:5], w[9:7], w[4:0], w[4:2]};
	endfunction

	function automatic rgb_t pal_colour(input clut_idx_t idx);
		return {idx, ~idx, idx ^ 8'h5a};  // Distinct and never black
	endfunction

	function automatic chan_t osd_expect(input chan_t c, input logic win, input logic pix,
		input logic blue);
		if (!win)
			return c;
		if (pix)
			return {2'b11, c[7:2]};
		return blue ? {2'b10, c[7:2]} : {2'b00, c[7:2]};  // Blue background
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checking and bus helpers
	//////////////////////////////////////////////////////////////////////
	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s at %0t ns", why, $time);
		$display("TESTS FAILED");
		$fatal(1, "Run aborted");
	endtask

	task automatic wb_cycle(input logic we, input logic [8:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		n        = 0;
		do begin
			@(negedge CLK_114);
			n++;
			if (n > TIMEOUT)
				abort_run("Timeout waiting for Wishbone ack");
		end while (!wb_ack);
		rdata = wb_dat_r;
		@(negedge CLK_114);  // Master samples ack on this edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		check_equal(wb_ack, 1'b0, "ack longer than one cycle");
	endtask

	task automatic wb_write(input logic [8:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		wb_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [8:0] adr, output logic [31:0] data);
		wb_cycle(1'b0, adr, 32'h0, data);
	endtask

	task automatic wait_req_low();
		int n;
		n = 0;
		while (mem_req !== 1'b0) begin
			@(negedge CLK_114);
			n++;
			if (n > TIMEOUT)
				abort_run("Timeout waiting for mem_req to fall");
		end
	endtask

	task automatic wait_req_rise(output addr_t addr);
		int n;
		wait_req_low();
		n = 0;
		while (mem_req !== 1'b1) begin
			@(negedge CLK_114);
			n++;
			if (n > TIMEOUT)
				abort_run("Timeout waiting for a memory request");
		end
		addr = mem_addr;  // Held stable for the whole burst
	endtask

	// Clocks from one native strobe to the next
	task automatic check_strobe_period(input int period, input string what);
		int n;
		int gap;
		n = 0;
		do begin
			@(negedge CLK_114);
			n++;
			if (n > TIMEOUT)
				abort_run("Timeout waiting for pixel_strobe");
		end while (pixel_strobe !== 1'b1);
		gap = 0;
		do begin
			@(negedge CLK_114);
			gap++;
			if (gap > TIMEOUT)
				abort_run("Timeout waiting for the next pixel_strobe");
		end while (pixel_strobe !== 1'b1);
		check_equal(gap, period, what);
	endtask

	// Two hsync edges end the stretched blank (vbend is 2)
	task automatic end_blank();
		repeat (2) begin
			in_hs = 1'b1;
			@(negedge CLK_114);
			in_hs = 1'b0;
			@(negedge CLK_114);
		end
	endtask

	// Walks distinct output colours, black and unknown are skipped
	task automatic match_colours(input string what);
		rgb_t cur;
		rgb_t prev;
		int   pos;
		int   n;
		logic started;
		pos     = 0;
		n       = 0;
		prev    = '0;
		started = 1'b0;
		while (pos < exp_seq.size()) begin
			@(negedge CLK_114);
			n++;
			if (n > TIMEOUT)
				abort_run({"Timeout waiting for ", what, " colours"});
			cur = {vga_r, vga_g, vga_b};
			if (!$isunknown(cur) && cur != '0 && cur != prev) begin
				if (cur == exp_seq[pos]) begin
					pos++;
					started = 1'b1;
				end else if (started) begin
					check_equal(cur, exp_seq[pos], what);
				end
				prev = cur;
			end
		end
	endtask

	task automatic check_burst_order(input addr_t base, input string what);
		addr_t got;
		addr_t want;
		for (int i = 0; i < FIFO_DEPTH / BURST_LEN; i++) begin  // Bursts that fit the FIFO
			wait_req_rise(got);
			want = base + addr_t'(i * BURST_LEN);
			check_equal(got, want, what);
		end
		wait_req_low();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_regs();
		logic [31:0] rd;
		check_equal(mem_req, 1'b0, "mem_req after reset");
		check_equal(wb_ack, 1'b0, "wb_ack after reset");
		check_equal(pixel_strobe, 1'b0, "pixel_strobe after reset");
		wb_read(REG_CTRL, rd);
		check_equal(rd, 32'h0, "CTRL after reset");
		wb_read(REG_TIMING, rd);
		check_equal(rd, 32'h0, "TIMING after reset");
		wb_read(REG_BASE, rd);
		check_equal(rd, 32'h0, "BASE after reset");
		wb_write(REG_CTRL, 32'hffff_fffe);  // All but enable
		wb_read(REG_CTRL, rd);
		check_equal(rd, 32'h0000_003e, "CTRL readback");
		wb_write(REG_TIMING, 32'hffff_ffff);
		wb_read(REG_TIMING, rd);
		check_equal(rd, 32'h0000_7f0f, "TIMING readback");
		wb_write(REG_BASE, 32'ha5c3_5a3c);
		wb_read(REG_BASE, rd);
		check_equal(rd, 32'h00c3_5a3c, "BASE readback");
		wb_write(9'(PAL_BASE + 7), 32'h00ab_cdef);
		wb_read(9'(PAL_BASE + 7), rd);
		check_equal(rd, 32'h0, "palette reads zero");
		wb_write(REG_CTRL, 32'h0);
		wb_write(REG_TIMING, 32'h0);
		wb_read(REG_TIMING, rd);
		check_equal(rd, 32'h0, "TIMING cleared");
	endtask

	task automatic test_native_colour();
		chan_t r;
		chan_t g;
		chan_t b;
		logic  win;
		logic  pix;
		for (int i = 0; i < 32; i++) begin
			r          = $random(seed);
			g          = $random(seed);
			b          = $random(seed);
			win        = (i >= 16);        // Second half inside the OSD
			pix        = $random(seed);
			in_r       = r;
			in_g       = g;
			in_b       = b;
			osd_window = win;
			osd_pixel  = pix;
			@(negedge CLK_114);
			check_equal(vga_r, osd_expect(r, win, pix, 1'b0), "native red");
			check_equal(vga_g, osd_expect(g, win, pix, 1'b0), "native green");
			check_equal(vga_b, osd_expect(b, win, pix, 1'b1), "native blue");
		end
		in_r       = '0;
		in_g       = '0;
		in_b       = '0;
		osd_window = 1'b0;
		osd_pixel  = 1'b0;
	endtask

	task automatic test_sync_polarity();
		logic hs;
		logic vs;
		logic cs;
		logic pol;
		for (int p = 0; p < 2; p++) begin
			pol = p[0];
			wb_write(REG_CTRL, {27'h0, pol, pol, 3'b000} );  // hpol and vpol
			for (int i = 0; i < 16; i++) begin
				hs    = $random(seed);
				vs    = $random(seed);
				cs    = $random(seed);
				in_hs = hs;
				in_vs = vs;
				in_cs = cs;
				@(negedge CLK_114);
				check_equal(vga_hs, hs ^ pol, "hsync output");
				check_equal(vga_vs, vs ^ pol, "vsync output");
				check_equal(vga_cs, cs, "csync output");
			end
		end
		in_hs = 1'b0;
		in_vs = 1'b0;
		in_cs = 1'b0;
		wb_write(REG_CTRL, 32'h0);
	endtask

	task automatic test_native_strobe();
		check_strobe_period(8, "native pixel_strobe period");
		wb_write(REG_CTRL, 32'h1 << CTRL_LOWRES);
		check_strobe_period(4, "lowres pixel_strobe period");
		wb_write(REG_CTRL, 32'h0);
	endtask

	task automatic test_fetch_order();
		wb_write(REG_TIMING, 32'h0000_0207);  // vbend 2, 8 clocks per word
		wb_write(REG_BASE, {8'h0, BASE});
		vblank = 1'b1;
		wb_write(REG_CTRL, 32'h1);
		@(negedge CLK_114);
		vblank = 1'b0;
		check_burst_order(BASE, "burst address after vblank");
	endtask

	task automatic test_high_colour();
		word_t w;
		exp_seq.delete();
		for (int i = 0; i < N_WORDS; i++) begin
			w = mem_word(BASE + addr_t'(i));
			exp_seq.push_back(expand_555(w));
		end
		end_blank();
		match_colours("high-colour");
	endtask

	task automatic test_clut();
		word_t w;
		for (int i = 0; i < 256; i++)
			wb_write(9'(PAL_BASE + i), {8'h0, pal_colour(clut_idx_t'(i))});
		wb_write(REG_BASE, {8'h0, CLUT_BASE});
		vblank = 1'b1;  // Restart the frame in indexed mode
		wb_write(REG_CTRL, 32'h3);
		@(negedge CLK_114);
		vblank = 1'b0;
		check_burst_order(CLUT_BASE, "burst address after CLUT restart");
		exp_seq.delete();
		for (int i = 0; i < N_WORDS / 2; i++) begin
			w = mem_word(CLUT_BASE + addr_t'(i));
			exp_seq.push_back(pal_colour(w[15:8]));  // High byte first
			exp_seq.push_back(pal_colour(w[7:0]));
		end
		end_blank();
		match_colours("CLUT");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		seed       = 46;
		rst_n      = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		in_r       = '0;
		in_g       = '0;
		in_b       = '0;
		in_hs      = 1'b0;
		in_vs      = 1'b0;
		in_cs      = 1'b0;
		hblank     = 1'b0;
		vblank     = 1'b0;
		osd_window = 1'b0;
		osd_pixel  = 1'b0;
		repeat (10) @(negedge CLK_114);
		rst_n = 1'b1;

		test_regs();
		test_native_colour();
		test_sync_polarity();
		test_native_strobe();
		test_fetch_order();
		test_high_colour();
		test_clut();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_rtg_mem_model.sv
/* Behavioural external memory for the RTG fetcher
   Answers each burst with address-derived words after random gaps */
`default_nettype none

module tb_rtg_mem_model #(
	parameter int BURST_LEN = rtg_pkg::BURST_LEN
) (
	input  wire                 CLK_114,
	input  wire                 mem_req,
	input  wire rtg_pkg::addr_t mem_addr,
	output logic                mem_fill,
	output rtg_pkg::word_t      mem_data
);
	timeunit 1ns;
	timeprecision 1ps;
	import rtg_pkg::*;

	integer seed;  // Gap generator state
	integer gap;
	int     k;

	function automatic word_t word_at(input addr_t a);
		return word_t'(a) + 16'h1234;  // Truncated address plus offset
	endfunction

	initial begin
		seed     = 46;
		mem_fill = 1'b0;
		mem_data = '0;
		forever begin
			@(negedge CLK_114);
			if (mem_req) begin
				for (int i = 0; i < BURST_LEN; i++) begin
					gap = $random(seed) & 3;  // 0..3 idle clocks
					repeat (gap) @(negedge CLK_114);
					mem_data = word_at(mem_addr + addr_t'(i));
					mem_fill = 1'b1;
					@(negedge CLK_114);
					mem_fill = 1'b0;
				end
				// Request drops after the last fill
				for (k = 0; k < 8 && mem_req; k++)
					@(negedge CLK_114);
			end
		end
	end

endmodule

`default_nettype wire
